//--- source/exec_defines.svh
// Execute stage widths

`ifndef EXEC_DEFINES_SVH
`define EXEC_DEFINES_SVH

// Datapath width of the processor
`define EXEC_DATA_W 16

// Register index width, eight registers
`define EXEC_REG_W 3

`endif

//--- source/execPkg.sv
// Execute stage types

`include "exec_defines.svh"

package execPkg;

    // Branch compares share op[4:2] = 011, set ops share op[4:2] = 111
    typedef enum logic [4:0] {
        opAdd  = 5'b00000,
        opSub  = 5'b00001,
        opAnd  = 5'b00010,
        opOr   = 5'b00011,
        opXor  = 5'b00100,
        opSll  = 5'b01000,
        opSrl  = 5'b01001,
        opRol  = 5'b01010,
        opRor  = 5'b01011,
        opBeqz = 5'b01100,
        opBnez = 5'b01101,
        opBltz = 5'b01110,
        opBgez = 5'b01111,
        opSlbi = 5'b10010,
        opLbi  = 5'b11000,
        opBtr  = 5'b11001,
        opSeq  = 5'b11100,
        opSlt  = 5'b11101,
        opSle  = 5'b11110,
        opSco  = 5'b11111
    } opT;

    // Operand source selects, same order as the forwarding mux inputs
    typedef enum logic [1:0] {
        fwdNone      = 2'b00,
        fwdMemWbAlu  = 2'b01,
        fwdExMemAlu  = 2'b10,
        fwdMemWbLoad = 2'b11
    } fwdSelT;

    typedef enum logic [2:0] {
        aluSll = 3'b000,
        aluSrl = 3'b001,
        aluRol = 3'b010,
        aluRor = 3'b011,
        aluAdd = 3'b100,
        aluAnd = 3'b101,
        aluOr  = 3'b110,
        aluXor = 3'b111
    } aluFuncT;

    typedef struct packed {
        opT                      op;
        logic [`EXEC_DATA_W-1:0] srcA;
        logic [`EXEC_DATA_W-1:0] srcB;
        logic [`EXEC_DATA_W-1:0] imm;
        logic                    useImm;
        logic [`EXEC_REG_W-1:0]  rsA;
        logic [`EXEC_REG_W-1:0]  rsB;
        logic                    usesA;
        logic                    usesB;
        logic [`EXEC_REG_W-1:0]  dest;
        logic                    writesReg;
        logic                    isLoad;
    } idExT;

    typedef struct packed {
        logic [`EXEC_DATA_W-1:0] result;
        logic                    zero;
        logic                    ltz;
        logic                    err;
        logic [`EXEC_REG_W-1:0]  dest;
        logic                    writesReg;
        logic                    isLoad;
    } exMemT;

    typedef struct packed {
        logic [`EXEC_DATA_W-1:0] aluResult;
        logic [`EXEC_DATA_W-1:0] loadData;
        logic [`EXEC_REG_W-1:0]  dest;
        logic                    writesReg;
        logic                    isLoad;
    } memWbT;

endpackage

//--- source/pipeReg.sv
// Pipeline register

module pipeReg #(
    parameter type payloadT = execPkg::exMemT
) (
    input  logic    clk,
    input  logic    arstN,
    input  logic    hold,
    input  logic    inValid,
    input  payloadT inData,
    output logic    outValid,
    output payloadT outData
);

    payloadT loadData;

    // A bubble keeps its fields but never writes a register
    always_comb begin
        loadData = inData;
        loadData.writesReg = inData.writesReg & inValid;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            outValid <= 1'b0;
            outData  <= '0;
        end else if (!hold) begin
            outValid <= inValid;
            outData  <= loadData;
        end
    end

endmodule

//--- source/aluCore.sv
// Execute stage ALU

`include "exec_defines.svh"

module aluCore (
    input  logic [`EXEC_DATA_W-1:0] inA,
    input  logic [`EXEC_DATA_W-1:0] inB,
    input  logic                    cIn,
    input  execPkg::aluFuncT        func,
    input  logic                    invA,
    input  logic                    invB,
    input  logic                    isSigned,
    output logic [`EXEC_DATA_W-1:0] out,
    output logic                    zero,
    output logic                    ltz,
    output logic                    ofl
);

    localparam int dataW = `EXEC_DATA_W;
    localparam int shW   = $clog2(dataW);

    logic [dataW-1:0]   opA;
    logic [dataW-1:0]   opB;
    logic [dataW-1:0]   sum;
    logic               cOut;
    logic               sOfl;
    logic [shW-1:0]     shAmt;
    logic [2*dataW-1:0] rotL;
    logic [2*dataW-1:0] rotR;

    assign opA = invA ? ~inA : inA;
    assign opB = invB ? ~inB : inB;

    assign {cOut, sum} = {1'b0, opA} + {1'b0, opB} + (dataW + 1)'(cIn);

    // Same operand signs but a different result sign
    assign sOfl = (opA[dataW-1] == opB[dataW-1]) && (sum[dataW-1] != opA[dataW-1]);

    // Shift amount from the low bits of B
    assign shAmt = opB[shW-1:0];
    assign rotL  = {opA, opA} << shAmt;
    assign rotR  = {opA, opA} >> shAmt;

    always_comb begin
        case (func)
            execPkg::aluSll: out = opA << shAmt;
            execPkg::aluSrl: out = opA >> shAmt;
            execPkg::aluRol: out = rotL[2*dataW-1:dataW];
            execPkg::aluRor: out = rotR[dataW-1:0];
            execPkg::aluAnd: out = opA & opB;
            execPkg::aluOr:  out = opA | opB;
            execPkg::aluXor: out = opA ^ opB;
            default:         out = sum;
        endcase
    end

    assign zero = ~|out;

    // Sign of the sum, corrected when it overflowed
    assign ltz = sum[dataW-1] ^ sOfl;

    assign ofl = isSigned ? sOfl : cOut;

endmodule

//--- source/forwardUnit.sv
// Operand forwarding unit

`include "exec_defines.svh"

module forwardUnit (
    input  logic [`EXEC_REG_W-1:0] rsA,
    input  logic [`EXEC_REG_W-1:0] rsB,
    input  logic                   usesA,
    input  logic                   usesB,
    input  logic [`EXEC_REG_W-1:0] exMemDest,
    input  logic                   exMemWrites,
    input  logic                   exMemIsLoad,
    input  logic [`EXEC_REG_W-1:0] memWbDest,
    input  logic                   memWbWrites,
    input  logic                   memWbIsLoad,
    output execPkg::fwdSelT        fwdA,
    output execPkg::fwdSelT        fwdB
);

    // Youngest producer wins; a load still in EX/MEM has no data yet
    function automatic execPkg::fwdSelT pickSrc(
        input logic [`EXEC_REG_W-1:0] rs,
        input logic                   uses
    );
        execPkg::fwdSelT sel;
        sel = execPkg::fwdNone;
        if (uses) begin
            if (exMemWrites && !exMemIsLoad && (exMemDest == rs)) begin
                sel = execPkg::fwdExMemAlu;
            end else if (memWbWrites && (memWbDest == rs)) begin
                sel = memWbIsLoad ? execPkg::fwdMemWbLoad : execPkg::fwdMemWbAlu;
            end
        end
        return sel;
    endfunction

    always_comb begin
        fwdA = pickSrc(rsA, usesA);
        fwdB = pickSrc(rsB, usesB);
    end

endmodule

//--- source/execute.sv
// Execute stage datapath

`include "exec_defines.svh"

module execute (
    input  execPkg::opT             op,
    input  logic [`EXEC_DATA_W-1:0] srcA,
    input  logic [`EXEC_DATA_W-1:0] srcB,
    input  logic [`EXEC_DATA_W-1:0] imm,
    input  logic                    useImm,
    input  execPkg::fwdSelT         fwdA,
    input  execPkg::fwdSelT         fwdB,
    input  logic [`EXEC_DATA_W-1:0] exMemResult,
    input  logic [`EXEC_DATA_W-1:0] memWbResult,
    input  logic [`EXEC_DATA_W-1:0] memWbLoad,
    output logic [`EXEC_DATA_W-1:0] result,
    output logic                    zero,
    output logic                    ltz,
    output logic                    err
);

    localparam int dataW = `EXEC_DATA_W;

    execPkg::aluFuncT aluFunc;
    logic             invA;
    logic             invB;
    logic             cIn;
    logic             isSigned;
    logic             isAddSub;
    logic             isBranch;
    logic             isSet;
    logic             isLbi;
    logic             isSlbi;
    logic             isBtr;
    logic [dataW-1:0] shapedA;
    logic [dataW-1:0] shapedB;
    logic [dataW-1:0] aluA;
    logic [dataW-1:0] aluB;
    logic [dataW-1:0] aluOut;
    logic             aluOfl;
    logic             setVal;
    logic [dataW-1:0] revA;

    function automatic logic [dataW-1:0] fwdMux(
        input execPkg::fwdSelT  sel,
        input logic [dataW-1:0] regVal
    );
        case (sel)
            execPkg::fwdMemWbAlu:  return memWbResult;
            execPkg::fwdExMemAlu:  return exMemResult;
            execPkg::fwdMemWbLoad: return memWbLoad;
            default:               return regVal;
        endcase
    endfunction

    // Op decode into ALU controls
    always_comb begin
        aluFunc  = execPkg::aluAdd;
        invA     = 1'b0;
        invB     = 1'b0;
        cIn      = 1'b0;
        isSigned = 1'b1;
        isAddSub = 1'b0;
        isBranch = 1'b0;
        isSet    = 1'b0;
        isLbi    = 1'b0;
        isSlbi   = 1'b0;
        isBtr    = 1'b0;
        case (op)
            execPkg::opAdd: isAddSub = 1'b1;
            // WISC subtract is B - A
            execPkg::opSub: begin
                invA     = 1'b1;
                cIn      = 1'b1;
                isAddSub = 1'b1;
            end
            execPkg::opAnd: aluFunc = execPkg::aluAnd;
            execPkg::opOr:  aluFunc = execPkg::aluOr;
            execPkg::opXor: aluFunc = execPkg::aluXor;
            execPkg::opSll: aluFunc = execPkg::aluSll;
            execPkg::opSrl: aluFunc = execPkg::aluSrl;
            execPkg::opRol: aluFunc = execPkg::aluRol;
            execPkg::opRor: aluFunc = execPkg::aluRor;
            execPkg::opBeqz, execPkg::opBnez, execPkg::opBltz, execPkg::opBgez: begin
                isBranch = 1'b1;
            end
            // Compare as A - B
            execPkg::opSeq, execPkg::opSlt, execPkg::opSle: begin
                invB  = 1'b1;
                cIn   = 1'b1;
                isSet = 1'b1;
            end
            execPkg::opSco: begin
                isSigned = 1'b0;
                isSet    = 1'b1;
            end
            execPkg::opLbi:  isLbi = 1'b1;
            execPkg::opSlbi: isSlbi = 1'b1;
            execPkg::opBtr:  isBtr = 1'b1;
            default: ;
        endcase
    end

    assign shapedA = isLbi ? '0 : (isSlbi ? (srcA << 8) : srcA);
    assign shapedB = isBranch ? '0 : (useImm ? imm : srcB);

    // Shaped operands are never replaced by forwarded values
    always_comb begin
        aluA = (isLbi || isSlbi) ? shapedA : fwdMux(fwdA, shapedA);
        aluB = (isBranch || useImm) ? shapedB : fwdMux(fwdB, shapedB);
    end

    aluCore aluCoreInst (
        .inA      (aluA),
        .inB      (aluB),
        .cIn      (cIn),
        .func     (aluFunc),
        .invA     (invA),
        .invB     (invB),
        .isSigned (isSigned),
        .out      (aluOut),
        .zero     (zero),
        .ltz      (ltz),
        .ofl      (aluOfl)
    );

    always_comb begin
        case (op)
            execPkg::opSeq: setVal = zero;
            execPkg::opSlt: setVal = ltz;
            execPkg::opSle: setVal = zero | ltz;
            default:        setVal = aluOfl;
        endcase
    end

    always_comb begin
        for (int i = 0; i < dataW; i++) begin
            revA[i] = aluA[dataW-1-i];
        end
    end

    assign result = isBtr ? revA : (isSet ? {{(dataW - 1){1'b0}}, setVal} : aluOut);

    assign err = aluOfl & isAddSub;

endmodule

//--- source/execStage.sv
// Execute portion of the pipeline
// ID/EX, execute, EX/MEM and MEM/WB

`include "exec_defines.svh"

module execStage (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    hold,
    input  logic                    inValid,
    input  execPkg::opT             inOp,
    input  logic [`EXEC_DATA_W-1:0] inSrcA,
    input  logic [`EXEC_DATA_W-1:0] inSrcB,
    input  logic [`EXEC_DATA_W-1:0] inImm,
    input  logic                    inUseImm,
    input  logic [`EXEC_REG_W-1:0]  inRsA,
    input  logic [`EXEC_REG_W-1:0]  inRsB,
    input  logic                    inUsesA,
    input  logic                    inUsesB,
    input  logic [`EXEC_REG_W-1:0]  inDest,
    input  logic                    inWrites,
    input  logic                    inIsLoad,
    input  logic [`EXEC_DATA_W-1:0] memRdData,
    output logic                    exValid,
    output logic [`EXEC_DATA_W-1:0] exResult,
    output logic                    exZero,
    output logic                    exLtz,
    output logic                    exErr,
    output logic [`EXEC_REG_W-1:0]  exDest,
    output logic                    exWrites,
    output logic                    exIsLoad,
    output logic                    wbValid,
    output logic [`EXEC_DATA_W-1:0] wbAluResult,
    output logic [`EXEC_DATA_W-1:0] wbLoadData,
    output logic [`EXEC_REG_W-1:0]  wbDest,
    output logic                    wbWrites,
    output logic                    wbIsLoad
);

    execPkg::idExT           idExD;
    execPkg::idExT           idExQ;
    logic                    idExValid;
    execPkg::exMemT          exMemD;
    execPkg::exMemT          exMemQ;
    execPkg::memWbT          memWbD;
    execPkg::memWbT          memWbQ;
    execPkg::fwdSelT         fwdA;
    execPkg::fwdSelT         fwdB;
    logic [`EXEC_DATA_W-1:0] exResultD;
    logic                    exZeroD;
    logic                    exLtzD;
    logic                    exErrD;

    assign idExD = '{
        op:        inOp,
        srcA:      inSrcA,
        srcB:      inSrcB,
        imm:       inImm,
        useImm:    inUseImm,
        rsA:       inRsA,
        rsB:       inRsB,
        usesA:     inUsesA,
        usesB:     inUsesB,
        dest:      inDest,
        writesReg: inWrites,
        isLoad:    inIsLoad
    };

    pipeReg #(.payloadT(execPkg::idExT)) idExReg (
        .clk      (clk),
        .arstN    (arstN),
        .hold     (hold),
        .inValid  (inValid),
        .inData   (idExD),
        .outValid (idExValid),
        .outData  (idExQ)
    );

    forwardUnit forwardUnitInst (
        .rsA         (idExQ.rsA),
        .rsB         (idExQ.rsB),
        .usesA       (idExQ.usesA),
        .usesB       (idExQ.usesB),
        .exMemDest   (exMemQ.dest),
        .exMemWrites (exMemQ.writesReg),
        .exMemIsLoad (exMemQ.isLoad),
        .memWbDest   (memWbQ.dest),
        .memWbWrites (memWbQ.writesReg),
        .memWbIsLoad (memWbQ.isLoad),
        .fwdA        (fwdA),
        .fwdB        (fwdB)
    );

    execute executeInst (
        .op          (idExQ.op),
        .srcA        (idExQ.srcA),
        .srcB        (idExQ.srcB),
        .imm         (idExQ.imm),
        .useImm      (idExQ.useImm),
        .fwdA        (fwdA),
        .fwdB        (fwdB),
        .exMemResult (exMemQ.result),
        .memWbResult (memWbQ.aluResult),
        .memWbLoad   (memWbQ.loadData),
        .result      (exResultD),
        .zero        (exZeroD),
        .ltz         (exLtzD),
        .err         (exErrD)
    );

    assign exMemD = '{
        result:    exResultD,
        zero:      exZeroD,
        ltz:       exLtzD,
        err:       exErrD,
        dest:      idExQ.dest,
        writesReg: idExQ.writesReg,
        isLoad:    idExQ.isLoad
    };

    pipeReg #(.payloadT(execPkg::exMemT)) exMemReg (
        .clk      (clk),
        .arstN    (arstN),
        .hold     (hold),
        .inValid  (idExValid),
        .inData   (exMemD),
        .outValid (exValid),
        .outData  (exMemQ)
    );

    // Memory read data joins the EX/MEM fields on the same edge
    assign memWbD = '{
        aluResult: exMemQ.result,
        loadData:  memRdData,
        dest:      exMemQ.dest,
        writesReg: exMemQ.writesReg,
        isLoad:    exMemQ.isLoad
    };

    pipeReg #(.payloadT(execPkg::memWbT)) memWbReg (
        .clk      (clk),
        .arstN    (arstN),
        .hold     (hold),
        .inValid  (exValid),
        .inData   (memWbD),
        .outValid (wbValid),
        .outData  (memWbQ)
    );

    assign exResult    = exMemQ.result;
    assign exZero      = exMemQ.zero;
    assign exLtz       = exMemQ.ltz;
    assign exErr       = exMemQ.err;
    assign exDest      = exMemQ.dest;
    assign exWrites    = exMemQ.writesReg;
    assign exIsLoad    = exMemQ.isLoad;

    assign wbAluResult = memWbQ.aluResult;
    assign wbLoadData  = memWbQ.loadData;
    assign wbDest      = memWbQ.dest;
    assign wbWrites    = memWbQ.writesReg;
    assign wbIsLoad    = memWbQ.isLoad;

endmodule

//--- test/execStage_chk.sv
// Execute stage reference checker

`include "exec_defines.svh"

module execStage_chk (
    input logic                    clk,
    input logic                    arstN,
    input logic                    hold,
    input logic                    inValid,
    input execPkg::opT             inOp,
    input logic [`EXEC_DATA_W-1:0] inSrcA,
    input logic [`EXEC_DATA_W-1:0] inSrcB,
    input logic [`EXEC_DATA_W-1:0] inImm,
    input logic                    inUseImm,
    input logic [`EXEC_REG_W-1:0]  inRsA,
    input logic [`EXEC_REG_W-1:0]  inRsB,
    input logic                    inUsesA,
    input logic                    inUsesB,
    input logic [`EXEC_REG_W-1:0]  inDest,
    input logic                    inWrites,
    input logic                    inIsLoad,
    input logic [`EXEC_DATA_W-1:0] memRdData,
    input logic                    exValid,
    input logic [`EXEC_DATA_W-1:0] exResult,
    input logic                    exZero,
    input logic                    exLtz,
    input logic                    exErr,
    input logic [`EXEC_REG_W-1:0]  exDest,
    input logic                    exWrites,
    input logic                    exIsLoad,
    input logic                    wbValid,
    input logic [`EXEC_DATA_W-1:0] wbAluResult,
    input logic [`EXEC_DATA_W-1:0] wbLoadData,
    input logic [`EXEC_REG_W-1:0]  wbDest,
    input logic                    wbWrites,
    input logic                    wbIsLoad
);

    int failCount = 0;

    execPkg::idExT  mId;
    execPkg::exMemT mEx;
    execPkg::memWbT mWb;
    logic           mIdV;
    logic           mExV;
    logic           mWbV;
    logic           mExBr;
    logic [15:0]    a;
    logic [15:0]    b;
    logic [15:0]    res;
    logic [16:0]    wide;
    logic           zf;
    logic           nf;
    logic           ef;
    logic           br;

    // Youngest in-flight producer of a register wins
    function automatic logic [15:0] regValue(input logic [2:0] rs, input logic [15:0] v);
        if (mEx.writesReg && !mEx.isLoad && mEx.dest == rs) begin
            return mEx.result;
        end else if (mWb.writesReg && mWb.dest == rs) begin
            return mWb.isLoad ? mWb.loadData : mWb.aluResult;
        end
        return v;
    endfunction

    always_comb begin
        br = mId.op inside {execPkg::opBeqz, execPkg::opBnez, execPkg::opBltz, execPkg::opBgez};
        a = mId.srcA;
        b = mId.useImm ? mId.imm : mId.srcB;
        if (mId.usesA && !(mId.op inside {execPkg::opLbi, execPkg::opSlbi})) begin
            a = regValue(mId.rsA, a);
        end
        if (mId.usesB && !mId.useImm && !br) begin
            b = regValue(mId.rsB, b);
        end
        if (br) b = '0;
        if (mId.op == execPkg::opLbi) a = '0;
        if (mId.op == execPkg::opSlbi) a = mId.srcA << 8;
        wide = {1'b0, a} + {1'b0, b};
        ef = 1'b0;
        case (mId.op)
            execPkg::opAdd: begin
                res = wide[15:0];
                ef = (a[15] == b[15]) && (res[15] != a[15]);
            end
            // Subtract is B minus A
            execPkg::opSub: begin
                res = b - a;
                ef = (a[15] != b[15]) && (res[15] != b[15]);
            end
            execPkg::opAnd: res = a & b;
            execPkg::opOr:  res = a | b;
            execPkg::opXor: res = a ^ b;
            execPkg::opSll: res = a << b[3:0];
            execPkg::opSrl: res = a >> b[3:0];
            execPkg::opRol: res = (a << b[3:0]) | (a >> (16 - b[3:0]));
            execPkg::opRor: res = (a >> b[3:0]) | (a << (16 - b[3:0]));
            execPkg::opSeq: res = {15'd0, a == b};
            execPkg::opSlt: res = {15'd0, $signed(a) < $signed(b)};
            execPkg::opSle: res = {15'd0, $signed(a) <= $signed(b)};
            execPkg::opSco: res = {15'd0, wide[16]};
            execPkg::opBtr: begin
                for (int i = 0; i < 16; i++) res[i] = a[15-i];
            end
            default: res = wide[15:0];
        endcase
        // Flags only checked for branch compares
        zf = (a == 16'd0);
        nf = a[15];
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            mIdV  <= 1'b0;
            mExV  <= 1'b0;
            mWbV  <= 1'b0;
            mExBr <= 1'b0;
            mId   <= '0;
            mEx   <= '0;
            mWb   <= '0;
        end else if (!hold) begin
            mWbV  <= mExV;
            mWb   <= '{mEx.result, memRdData, mEx.dest, mEx.writesReg, mEx.isLoad};
            mExV  <= mIdV;
            mExBr <= br;
            mEx   <= '{res, zf, nf, ef, mId.dest, mId.writesReg, mId.isLoad};
            mIdV  <= inValid;
            mId   <= '{inOp, inSrcA, inSrcB, inImm, inUseImm, inRsA, inRsB, inUsesA, inUsesB,
                       inDest, inWrites & inValid, inIsLoad};
        end
    end

    resultOk: assert property (@(posedge clk) disable iff (!arstN)
        exValid |-> exResult == mEx.result)
    else begin
        $error("error at %0t: exResult %h expected %h", $time, exResult, mEx.result);
        failCount = failCount + 1;
    end

    errOk: assert property (@(posedge clk) disable iff (!arstN)
        exValid |-> exErr == mEx.err)
    else begin
        $error("error at %0t: exErr %b expected %b", $time, exErr, mEx.err);
        failCount = failCount + 1;
    end

    flagsOk: assert property (@(posedge clk) disable iff (!arstN)
        (exValid && mExBr) |-> (exZero == mEx.zero && exLtz == mEx.ltz))
    else begin
        $error("error at %0t: branch flags z=%b n=%b wrong", $time, exZero, exLtz);
        failCount = failCount + 1;
    end

    // Bubbles must carry writes low, valid slots carry their tags
    exTagsOk: assert property (@(posedge clk) disable iff (!arstN)
        (exWrites == mEx.writesReg) &&
        (!exValid || (exDest == mEx.dest && exIsLoad == mEx.isLoad)))
    else begin
        $error("error at %0t: EX/MEM dest %0d writes %b load %b wrong", $time, exDest,
               exWrites, exIsLoad);
        failCount = failCount + 1;
    end

    wbOk: assert property (@(posedge clk) disable iff (!arstN)
        (wbWrites == mWb.writesReg) &&
        (!wbValid || (wbAluResult == mWb.aluResult && wbLoadData == mWb.loadData &&
                      wbDest == mWb.dest && wbIsLoad == mWb.isLoad)))
    else begin
        $error("error at %0t: MEM/WB result %h load %h expected %h %h", $time, wbAluResult,
               wbLoadData, mWb.aluResult, mWb.loadData);
        failCount = failCount + 1;
    end

    validOk: assert property (@(posedge clk) exValid == mExV && wbValid == mWbV)
    else begin
        $error("error at %0t: valid bits ex=%b wb=%b wrong", $time, exValid, wbValid);
        failCount = failCount + 1;
    end

    holdOk: assert property (@(posedge clk) disable iff (!arstN)
        hold |=> ($stable(exResult) && $stable(exValid)))
    else begin
        $error("error at %0t: EX/MEM changed during hold", $time);
        failCount = failCount + 1;
    end

endmodule

//--- test/execStage_tb.sv
// Execute stage testbench

`include "exec_defines.svh"

module execStage_tb;

    logic                    clk = 1'b0;
    logic                    arstN;
    logic                    hold;
    logic                    inValid;
    execPkg::opT             inOp;
    logic [`EXEC_DATA_W-1:0] inSrcA;
    logic [`EXEC_DATA_W-1:0] inSrcB;
    logic [`EXEC_DATA_W-1:0] inImm;
    logic                    inUseImm;
    logic [`EXEC_REG_W-1:0]  inRsA;
    logic [`EXEC_REG_W-1:0]  inRsB;
    logic                    inUsesA;
    logic                    inUsesB;
    logic [`EXEC_REG_W-1:0]  inDest;
    logic                    inWrites;
    logic                    inIsLoad;
    logic [`EXEC_DATA_W-1:0] memRdData;
    logic                    exValid;
    logic [`EXEC_DATA_W-1:0] exResult;
    logic                    exZero;
    logic                    exLtz;
    logic                    exErr;
    logic [`EXEC_REG_W-1:0]  exDest;
    logic                    exWrites;
    logic                    exIsLoad;
    logic                    wbValid;
    logic [`EXEC_DATA_W-1:0] wbAluResult;
    logic [`EXEC_DATA_W-1:0] wbLoadData;
    logic [`EXEC_REG_W-1:0]  wbDest;
    logic                    wbWrites;
    logic                    wbIsLoad;

    logic [31:0] seed = 32'h398b;
    int          timeouts = 0;
    int          passed = 0;
    int          failed = 0;
    int          startFails;

    always #4 clk = ~clk;

    bind execStage execStage_chk chkInst (.*);

    execStage execStage_inst (.*);

    function automatic logic [15:0] nextRand();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed[31:16];
    endfunction

    // Drive one instruction a unit after the edge, sampled on the next edge
    task automatic issue(input execPkg::opT op, input logic [15:0] a, input logic [15:0] b,
                         input logic [15:0] imm, input logic useImm, input logic [2:0] rsA,
                         input logic [2:0] rsB, input logic [2:0] dest, input logic isLoad);
        inValid   = 1'b1;
        inOp      = op;
        inSrcA    = a;
        inSrcB    = b;
        inImm     = imm;
        inUseImm  = useImm;
        inRsA     = rsA;
        inRsB     = rsB;
        inUsesA   = 1'b1;
        inUsesB   = !useImm;
        inDest    = dest;
        inWrites  = 1'b1;
        inIsLoad  = isLoad;
        memRdData = nextRand();
        @(posedge clk);
        #1;
        inValid  = 1'b0;
        inWrites = 1'b0;
    endtask

    // Let the pipe empty, with a cycle limit
    task automatic drain();
        int n;
        n = 0;
        while ((exValid || wbValid || n < 2) && n < 20) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (exValid || wbValid) begin
            $display("timeout: pipeline did not drain at %0t", $time);
            timeouts++;
        end
    endtask

    task automatic finishTest(input string name);
        drain();
        if (execStage_inst.chkInst.failCount == startFails) begin
            passed++;
            $display("test %s: ok", name);
        end else begin
            failed++;
            $display("test %s: failed", name);
        end
        startFails = execStage_inst.chkInst.failCount;
    endtask

    initial begin
        execPkg::opT arith[9];
        execPkg::opT sets[8];
        int n;
        arith = '{execPkg::opAdd, execPkg::opSub, execPkg::opAnd, execPkg::opOr,
                  execPkg::opXor, execPkg::opSll, execPkg::opSrl, execPkg::opRol,
                  execPkg::opRor};
        sets = '{execPkg::opSeq, execPkg::opSlt, execPkg::opSle, execPkg::opSco,
                 execPkg::opBeqz, execPkg::opBnez, execPkg::opBltz, execPkg::opBgez};
        arstN = 1'b0;
        hold = 1'b0;
        inValid = 1'b0;
        inOp = execPkg::opAdd;
        {inSrcA, inSrcB, inImm, memRdData} = '0;
        {inUseImm, inRsA, inRsB, inUsesA, inUsesB, inDest, inWrites, inIsLoad} = '0;
        startFails = 0;
        repeat (16) @(posedge clk);
        #1;
        arstN = 1'b1;
        finishTest("reset");

        // Sources r0 and r1, results to r7, so nothing forwards
        for (int i = 0; i < 60; i++) begin
            issue(arith[i % 9], nextRand(), nextRand(), 16'd0, 1'b0, 3'd0, 3'd1, 3'd7, 1'b0);
        end
        issue(execPkg::opAdd, 16'h7fff, 16'h0001, 16'd0, 1'b0, 3'd0, 3'd1, 3'd7, 1'b0);
        issue(execPkg::opSub, 16'h0001, 16'h8000, 16'd0, 1'b0, 3'd0, 3'd1, 3'd7, 1'b0);
        finishTest("arith");

        for (int i = 0; i < 48; i++) begin
            issue(sets[i % 8], (i % 5 == 0) ? 16'd0 : nextRand(),
                  (i % 3 == 0) ? 16'd0 : nextRand(), 16'd0, 1'b0, 3'd0, 3'd1, 3'd7, 1'b0);
        end
        // Equal operands separate sle from slt
        issue(execPkg::opSlt, 16'h8001, 16'h8001, 16'd0, 1'b0, 3'd0, 3'd1, 3'd7, 1'b0);
        issue(execPkg::opSle, 16'h8001, 16'h8001, 16'd0, 1'b0, 3'd0, 3'd1, 3'd7, 1'b0);
        finishTest("set and branch");

        issue(execPkg::opLbi, nextRand(), 16'd0, nextRand(), 1'b1, 3'd0, 3'd1, 3'd7, 1'b0);
        issue(execPkg::opSlbi, nextRand(), 16'd0, 16'h00a5, 1'b1, 3'd0, 3'd1, 3'd7, 1'b0);
        issue(execPkg::opBtr, 16'h1234, 16'd0, 16'd0, 1'b0, 3'd0, 3'd1, 3'd7, 1'b0);
        finishTest("special");

        // Back to back, two apart, after a load, and a double match
        issue(execPkg::opAdd, nextRand(), nextRand(), 16'd0, 1'b0, 3'd0, 3'd1, 3'd2, 1'b0);
        issue(execPkg::opXor, 16'd0, nextRand(), 16'd0, 1'b0, 3'd2, 3'd1, 3'd3, 1'b0);
        issue(execPkg::opOr, 16'd0, nextRand(), 16'd0, 1'b0, 3'd0, 3'd1, 3'd4, 1'b0);
        issue(execPkg::opSub, 16'd0, 16'd0, 16'd0, 1'b0, 3'd3, 3'd1, 3'd5, 1'b0);
        issue(execPkg::opAdd, nextRand(), 16'd0, 16'd4, 1'b1, 3'd0, 3'd1, 3'd6, 1'b1);
        issue(execPkg::opAnd, nextRand(), nextRand(), 16'd0, 1'b0, 3'd0, 3'd1, 3'd4, 1'b0);
        issue(execPkg::opAdd, 16'd0, nextRand(), 16'd0, 1'b0, 3'd6, 3'd1, 3'd5, 1'b0);
        issue(execPkg::opAdd, nextRand(), nextRand(), 16'd0, 1'b0, 3'd0, 3'd1, 3'd2, 1'b0);
        issue(execPkg::opSub, nextRand(), nextRand(), 16'd0, 1'b0, 3'd0, 3'd1, 3'd2, 1'b0);
        issue(execPkg::opXor, 16'd0, 16'd0, 16'd0, 1'b0, 3'd2, 3'd2, 3'd3, 1'b0);
        finishTest("forwarding");

        issue(execPkg::opAdd, nextRand(), nextRand(), 16'd0, 1'b0, 3'd0, 3'd1, 3'd2, 1'b0);
        hold = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        hold = 1'b0;
        n = 0;
        while (!exValid && n < 10) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (!exValid) begin
            $display("timeout: no result after hold at %0t", $time);
            timeouts++;
        end
        finishTest("hold");

        $display("tests passed %0d failed %0d timeouts %0d", passed, failed, timeouts);
        if (failed == 0 && timeouts == 0 && execStage_inst.chkInst.failCount == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

//--- list.f
+incdir+source
source/execPkg.sv
source/pipeReg.sv
source/aluCore.sv
source/forwardUnit.sv
source/execute.sv
source/execStage.sv
test/execStage_chk.sv
test/execStage_tb.sv

//--- run.sh
#!/bin/sh
# Build and run the execute stage testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --assert -f list.f --top-module execStage_tb --Mdir obj_dir -o simExec
if [ $? -ne 0 ]; then
    echo "compile failed"
    exit 1
fi

output=$(./obj_dir/simExec +verilator+error+limit+1000)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
    echo "simulation returned status $status"
    exit 1
fi

if echo "$output" | grep -q "TB PASSED"; then
    exit 0
fi
exit 1
